// ==== flist.f ====
logic/mips_pkg.sv
logic/fetch_pc.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/mips_alu.sv
logic/mem_align.sv
logic/mips_core.sv
tb/tb_clock.sv
tb/tb_mem.sv
tb/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the mips_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module mips_core_tb -Mdir obj_dir -o mips_core_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/mips_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
   echo "simulation result: pass"
   exit 0
fi

echo "simulation result: fail"
exit 1

// ==== tb/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

   localparam int max_cycles = 2000;
   // result and marker registers of the test programs
   localparam int r_res  = 10;
   localparam int r_mark = 20;

   logic             clk;
   logic             rst_b;
   logic             fill;
   mips_pkg::waddr_t inst_addr;
   mips_pkg::word_t  inst;
   mips_pkg::waddr_t mem_addr;
   mips_pkg::word_t  mem_data_in;
   logic [3:0]       mem_write_en;
   mips_pkg::word_t  mem_data_out;
   logic             halted;

   // expected image of the data memory
   mips_pkg::word_t exp_dmem [256];
   int              pc_n;
   int              slot;

   tb_clock clk_gen (.clk);

   tb_mem mem (
      .clk, .fill, .inst_addr, .inst, .mem_addr, .mem_data_in, .mem_write_en, .mem_data_out
   );

   mips_core uut (
      .clk, .rst_b, .inst_addr, .inst, .mem_addr, .mem_data_in, .mem_write_en,
      .mem_data_out, .halted
   );

   // instruction encoders
   function automatic mips_pkg::word_t r_op(int rs, int rt, int rd, int sh, logic [5:0] fn);
      return {mips_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic mips_pkg::word_t i_op(logic [5:0] op, int rs, int rt, logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   // jump to instruction slot idx of the program
   function automatic mips_pkg::word_t j_op(logic [5:0] op, int idx);
      mips_pkg::word_t dest;
      dest = mips_pkg::text_start + 32'(idx) * 32'd4;
      return {op, dest[27:2]};
   endfunction

   function automatic mips_pkg::word_t sext16(logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic mips_pkg::word_t data_fill(int i);
      return {16'hd00d, ~i[7:0], i[7:0]};
   endfunction

   // word address of program slot idx
   function automatic mips_pkg::word_t fetch_word(int idx);
      return (mips_pkg::text_start >> 2) + 32'(idx);
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic compare(string name, mips_pkg::word_t got, mips_pkg::word_t expected);
      if (got !== expected) begin
         abort_run($sformatf("error: %s is %h, expected %h", name, got, expected));
      end
   endtask

   task automatic emit(mips_pkg::word_t w);
      mem.imem[pc_n] = w;
      pc_n++;
   endtask

   task automatic load_const(int r, mips_pkg::word_t v);
      emit(i_op(mips_pkg::op_lui, 0, r, v[31:16]));
      emit(i_op(mips_pkg::op_ori, r, r, v[15:0]));
   endtask

   // sw to data word idx, recorded as expected
   task automatic store_expected(int rt, int idx, mips_pkg::word_t value);
      emit(i_op(mips_pkg::op_sw, 0, rt, 16'(idx * 4)));
      exp_dmem[idx] = value;
   endtask

   // marker store that must never execute
   task automatic dead_store(int idx);
      emit(i_op(mips_pkg::op_sw, 0, r_mark, 16'(idx * 4)));
   endtask

   // instruction writing r_res, then store it to the next slot
   task automatic result_store(mips_pkg::word_t instr, mips_pkg::word_t value);
      emit(instr);
      store_expected(r_res, slot, value);
      slot++;
   endtask

   task automatic start_program();
      @(negedge clk);
      rst_b = 1'b0;
      fill  = 1'b1;
      // stray fetches hit a reserved opcode
      for (int i = 0; i < 256; i++) begin
         mem.imem[i] = {6'h3f, 18'h2a5a5, 8'(i)};
         exp_dmem[i] = data_fill(i);
      end
      pc_n = 0;
      slot = 0;
   endtask

   task automatic inspect_reset();
      compare("halted", 32'(halted), 32'h0);
      compare("mem_write_en", 32'(mem_write_en), 32'h0);
      compare("inst_addr", 32'(inst_addr), fetch_word(0));
   endtask

   // reset for 8 cycles, release, run until halted
   task automatic run_to_halt(output int cycles);
      repeat (8) @(negedge clk);
      fill = 1'b0;
      inspect_reset();
      rst_b = 1'b1;
      #2;
      inspect_reset();
      cycles = 0;
      while (!halted) begin
         @(negedge clk);
         cycles++;
         if (cycles > max_cycles) begin
            abort_run("timeout: the core did not halt");
         end
      end
   endtask

   task automatic verify_data();
      for (int i = 0; i < 256; i++) begin
         compare($sformatf("dmem[%0d]", i), mem.dmem[i], exp_dmem[i]);
      end
   endtask

   // core must stay frozen on slot idx
   task automatic watch_halt(int idx);
      repeat (20) begin
         @(negedge clk);
         compare("halted", 32'(halted), 32'h1);
         compare("inst_addr", 32'(inst_addr), fetch_word(idx));
      end
   endtask

   task automatic reset_values();
      int cycles;
      start_program();
      // nop, then syscall
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_sll));
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      compare("inst_addr", 32'(inst_addr), fetch_word(1));
      verify_data();
   endtask

   task automatic arith_logic();
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      logic [15:0]     imm;
      int              cycles;
      a   = $urandom;
      b   = $urandom;
      // top bit set shows sign versus zero extension
      imm = 16'($urandom) | 16'h8000;
      start_program();
      load_const(8, a);
      load_const(9, b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_add), a + b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_addu), a + b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_sub), a - b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_subu), a - b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_and), a & b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_or), a | b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_xor), a ^ b);
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_nor), ~(a | b));
      // both orders, so one of them is true
      result_store(r_op(8, 9, r_res, 0, mips_pkg::fn_slt), 32'($signed(a) < $signed(b)));
      result_store(r_op(9, 8, r_res, 0, mips_pkg::fn_slt), 32'($signed(b) < $signed(a)));
      result_store(i_op(mips_pkg::op_addi, 8, r_res, imm), a + sext16(imm));
      result_store(i_op(mips_pkg::op_addiu, 8, r_res, imm), a + sext16(imm));
      result_store(i_op(mips_pkg::op_andi, 8, r_res, imm), a & {16'h0000, imm});
      result_store(i_op(mips_pkg::op_ori, 8, r_res, imm), a | {16'h0000, imm});
      result_store(i_op(mips_pkg::op_xori, 8, r_res, imm), a ^ {16'h0000, imm});
      result_store(i_op(mips_pkg::op_slti, 8, r_res, imm),
                   32'($signed(a) < $signed(sext16(imm))));
      result_store(i_op(mips_pkg::op_lui, 0, r_res, imm), {imm, 16'h0000});
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      verify_data();
   endtask

   task automatic shift_ops();
      mips_pkg::word_t v;
      mips_pkg::word_t amt;
      int              sh;
      int              cycles;
      v   = $urandom | 32'h8000_0000;
      amt = $urandom;
      sh  = $urandom_range(31, 1);
      start_program();
      load_const(8, v);
      load_const(11, amt);
      result_store(r_op(0, 8, r_res, sh, mips_pkg::fn_sll), v << sh);
      result_store(r_op(0, 8, r_res, sh, mips_pkg::fn_srl), v >> sh);
      result_store(r_op(0, 8, r_res, sh, mips_pkg::fn_sra), $signed(v) >>> sh);
      // variable amount is the low five bits of rs
      result_store(r_op(11, 8, r_res, 0, mips_pkg::fn_sllv), v << amt[4:0]);
      result_store(r_op(11, 8, r_res, 0, mips_pkg::fn_srlv), v >> amt[4:0]);
      result_store(r_op(11, 8, r_res, 0, mips_pkg::fn_srav), $signed(v) >>> amt[4:0]);
      // writes into $zero are lost
      emit(r_op(0, 8, 0, 4, mips_pkg::fn_sll));
      emit(r_op(8, 8, 0, 0, mips_pkg::fn_add));
      store_expected(0, slot, 32'h0);
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      verify_data();
   endtask

   task automatic byte_access();
      logic [7:0] bt [4];
      int         order [4] = '{2, 0, 3, 1};
      int         cycles;
      for (int k = 0; k < 4; k++) begin
         bt[k] = 8'($urandom);
      end
      bt[1][7] = 1'b1;
      bt[2][7] = 1'b0;
      start_program();
      // word 64 gets one lane per sb, upper bits of rt are junk
      for (int k = 0; k < 4; k++) begin
         load_const(12, {24'($urandom), bt[order[k]]});
         emit(i_op(mips_pkg::op_sb, 0, 12, 16'(256 + order[k])));
      end
      exp_dmem[64] = {bt[0], bt[1], bt[2], bt[3]};
      result_store(i_op(mips_pkg::op_lb, 0, r_res, 16'd257), {{24{bt[1][7]}}, bt[1]});
      result_store(i_op(mips_pkg::op_lbu, 0, r_res, 16'd257), {24'h000000, bt[1]});
      result_store(i_op(mips_pkg::op_lb, 0, r_res, 16'd258), {{24{bt[2][7]}}, bt[2]});
      result_store(i_op(mips_pkg::op_lw, 0, r_res, 16'd256), {bt[0], bt[1], bt[2], bt[3]});
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      verify_data();
   endtask

   task automatic control_flow();
      mips_pkg::word_t marker;
      int              loop_top;
      int              jal_at;
      int              cycles;
      marker = $urandom;
      start_program();
      load_const(r_mark, marker);
      emit(i_op(mips_pkg::op_addi, 0, 1, 16'd5));
      emit(i_op(mips_pkg::op_addi, 0, 2, 16'd5));
      emit(i_op(mips_pkg::op_addi, 0, 3, 16'd7));
      // beq taken skips one store
      emit(i_op(mips_pkg::op_beq, 1, 2, 16'd1));
      dead_store(32);
      store_expected(r_mark, 33, marker);
      // beq not taken falls through
      emit(i_op(mips_pkg::op_beq, 1, 3, 16'd1));
      store_expected(r_mark, 34, marker);
      store_expected(r_mark, 35, marker);
      emit(i_op(mips_pkg::op_bne, 1, 3, 16'd1));
      dead_store(36);
      store_expected(r_mark, 37, marker);
      emit(i_op(mips_pkg::op_bne, 1, 2, 16'd1));
      store_expected(r_mark, 38, marker);
      // backward bne, three passes counted in r5
      emit(i_op(mips_pkg::op_addi, 0, 4, 16'd3));
      loop_top = pc_n;
      emit(i_op(mips_pkg::op_addi, 5, 5, 16'd1));
      emit(i_op(mips_pkg::op_addi, 4, 4, 16'hffff));
      emit(i_op(mips_pkg::op_bne, 4, 0, 16'(loop_top - (pc_n + 1))));
      store_expected(5, 40, 32'd3);
      // j over one store
      emit(j_op(mips_pkg::op_j, pc_n + 2));
      dead_store(41);
      store_expected(r_mark, 42, marker);
      // jal to a routine at jal_at+3, which returns through $ra
      jal_at = pc_n;
      emit(j_op(mips_pkg::op_jal, jal_at + 3));
      store_expected(r_mark, 43, marker);
      emit(j_op(mips_pkg::op_j, jal_at + 6));
      store_expected(31, 44, mips_pkg::text_start + 32'(jal_at + 1) * 32'd4);
      store_expected(r_mark, 45, marker);
      emit(r_op(31, 0, 0, 0, mips_pkg::fn_jr));
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      verify_data();
   endtask

   task automatic halt_behaviour();
      mips_pkg::word_t marker;
      int              cycles;
      marker = $urandom;
      start_program();
      load_const(r_mark, marker);
      store_expected(r_mark, 50, marker);
      // syscall in slot 3, halted after its own edge
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      compare("halt cycles", 32'(cycles), 32'd4);
      watch_halt(3);
      verify_data();
      // reserved opcode in slot 2, the store behind it never runs
      start_program();
      load_const(r_mark, marker);
      emit({6'h3f, 26'h0});
      dead_store(51);
      emit(r_op(0, 0, 0, 0, mips_pkg::fn_syscall));
      run_to_halt(cycles);
      compare("halt cycles", 32'(cycles), 32'd3);
      watch_halt(2);
      verify_data();
   endtask

   initial begin
      rst_b = 1'b0;
      fill  = 1'b1;
      pc_n  = 0;
      slot  = 0;
      void'($urandom(32'h5f8b));
      reset_values();
      arith_logic();
      shift_ops();
      byte_access();
      control_flow();
      halt_behaviour();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== tb/tb_mem.sv ====
`timescale 1ns/1ps

module tb_mem (
   input  logic             clk,
   input  logic             fill,
   input  mips_pkg::waddr_t inst_addr,
   output mips_pkg::word_t  inst,
   input  mips_pkg::waddr_t mem_addr,
   input  mips_pkg::word_t  mem_data_in,
   input  logic [3:0]       mem_write_en,
   output mips_pkg::word_t  mem_data_out
);

   // program words, loaded by the testbench
   mips_pkg::word_t imem [256];
   mips_pkg::word_t dmem [256];

   // both ports answer in the same cycle
   assign inst         = imem[inst_addr[7:0]];
   assign mem_data_out = dmem[mem_addr[7:0]];

   always @(posedge clk) begin
      if (fill) begin
         // known background, different in every word
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= {16'hd00d, ~i[7:0], i[7:0]};
         end
      end else begin
         // lane 3 holds big-endian byte 0
         if (mem_write_en[3]) begin
            dmem[mem_addr[7:0]][31:24] <= mem_data_in[31:24];
         end
         if (mem_write_en[2]) begin
            dmem[mem_addr[7:0]][23:16] <= mem_data_in[23:16];
         end
         if (mem_write_en[1]) begin
            dmem[mem_addr[7:0]][15:8] <= mem_data_in[15:8];
         end
         if (mem_write_en[0]) begin
            dmem[mem_addr[7:0]][7:0] <= mem_data_in[7:0];
         end
      end
   end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   // free running, 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

endmodule

// ==== logic/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
   input  logic              clk,
   input  logic              rst_b,
   output mips_pkg::waddr_t  inst_addr,
   input  mips_pkg::word_t   inst,
   output mips_pkg::waddr_t  mem_addr,
   output mips_pkg::word_t   mem_data_in,
   output logic [3:0]        mem_write_en,
   input  mips_pkg::word_t   mem_data_out,
   output logic              halted
);

   mips_pkg::inst_fields_t fields;
   mips_pkg::ctrl_t        ctrl;
   mips_pkg::word_t        pc;
   mips_pkg::word_t        pc_plus4;
   mips_pkg::word_t        rs_data;
   mips_pkg::word_t        rt_data;
   mips_pkg::word_t        alu_b;
   mips_pkg::word_t        alu_result;
   mips_pkg::word_t        load_data;
   mips_pkg::word_t        wb_data;
   mips_pkg::reg_idx_t     wr_idx;
   logic                   is_load;

   fetch_pc u_fetch (.clk, .rst_b, .ctrl, .fields, .rs_data, .rt_data, .pc, .pc_plus4);

   inst_decode u_decode (.inst, .fields, .ctrl);

   reg_file u_regs (
      .clk, .rst_b,
      .rs_idx(fields.rs), .rt_idx(fields.rt),
      .wr_idx, .wr_data(wb_data), .wr_en(ctrl.reg_write),
      .rs_data, .rt_data
   );

   // second operand is rt or the extended immediate
   assign alu_b = ctrl.alu_src_imm ? fields.imm : rt_data;

   mips_alu u_alu (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .shamt(fields.shamt),
                   .result(alu_result));

   mem_align u_align (
      .kind(ctrl.mem_kind), .byte_off(alu_result[1:0]), .rt_data, .mem_data_out,
      .mem_data_in, .mem_write_en, .load_data
   );

   assign inst_addr = pc[31:2];
   assign mem_addr  = alu_result[31:2];

   // write-back select, jal links pc+4 into $ra
   assign is_load = (ctrl.mem_kind == mips_pkg::mem_lw) ||
                    (ctrl.mem_kind == mips_pkg::mem_lb) ||
                    (ctrl.mem_kind == mips_pkg::mem_lbu);
   assign wb_data = is_load ? load_data : (ctrl.link ? pc_plus4 : alu_result);
   assign wr_idx  = ctrl.link ? mips_pkg::reg_ra : (ctrl.dest_rd ? fields.rd : fields.rt);

   // sticky halt flag
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (ctrl.halt_req) begin
         halted <= 1'b1;
      end
   end

endmodule

// ==== logic/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
   input  mips_pkg::mem_kind_t kind,
   input  logic [1:0]          byte_off,
   input  mips_pkg::word_t     rt_data,
   input  mips_pkg::word_t     mem_data_out,
   output mips_pkg::word_t     mem_data_in,
   output logic [3:0]          mem_write_en,
   output mips_pkg::word_t     load_data
);

   logic [7:0] ld_byte;

   // big-endian: offset 0 lives in bits 31 to 24
   always_comb begin
      case (byte_off)
         2'd0:    ld_byte = mem_data_out[31:24];
         2'd1:    ld_byte = mem_data_out[23:16];
         2'd2:    ld_byte = mem_data_out[15:8];
         default: ld_byte = mem_data_out[7:0];
      endcase
   end

   always_comb begin
      case (kind)
         mips_pkg::mem_lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
         mips_pkg::mem_lbu: load_data = {24'h000000, ld_byte};
         default:           load_data = mem_data_out;
      endcase
   end

   // store byte is replicated on every lane, enable picks one
   always_comb begin
      case (kind)
         mips_pkg::mem_sw: begin
            mem_data_in  = rt_data;
            mem_write_en = 4'b1111;
         end
         mips_pkg::mem_sb: begin
            mem_data_in  = {4{rt_data[7:0]}};
            mem_write_en = 4'b1000 >> byte_off;
         end
         default: begin
            mem_data_in  = rt_data;
            mem_write_en = 4'b0000;
         end
      endcase
   end

endmodule

// ==== logic/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
   input  mips_pkg::alu_op_t   op,
   input  mips_pkg::word_t     a,
   input  mips_pkg::word_t     b,
   input  mips_pkg::reg_idx_t  shamt,
   output mips_pkg::word_t     result
);

   // variable shift amount from low bits of rs
   mips_pkg::reg_idx_t var_amt;
   logic               a_lt_b;

   assign var_amt = a[4:0];
   assign a_lt_b  = $signed(a) < $signed(b);

   always_comb begin
      case (op)
         mips_pkg::alu_add: result = a + b;
         mips_pkg::alu_sub: result = a - b;
         mips_pkg::alu_and: result = a & b;
         mips_pkg::alu_or:  result = a | b;
         mips_pkg::alu_xor: result = a ^ b;
         mips_pkg::alu_nor: result = ~(a | b);
         mips_pkg::alu_slt: result = {31'b0, a_lt_b};
         // fixed shifts move rt by the shamt field
         mips_pkg::alu_sll: result = b << shamt;
         mips_pkg::alu_srl: result = b >> shamt;
         mips_pkg::alu_sra: result = $signed(b) >>> shamt;
         mips_pkg::alu_sllv: result = b << var_amt;
         mips_pkg::alu_srlv: result = b >> var_amt;
         mips_pkg::alu_srav: result = $signed(b) >>> var_amt;
         // immediate goes to the upper half
         mips_pkg::alu_lui: result = {b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_idx_t  rs_idx,
   input  mips_pkg::reg_idx_t  rt_idx,
   input  mips_pkg::reg_idx_t  wr_idx,
   input  mips_pkg::word_t     wr_data,
   input  logic                wr_en,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);

   mips_pkg::word_t regs [32];

   // $zero never takes a write
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_idx != '0)) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // combinational read ports
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
   input  mips_pkg::word_t        inst,
   output mips_pkg::inst_fields_t fields,
   output mips_pkg::ctrl_t        ctrl
);

   logic [5:0] opcode;
   logic [5:0] funct;
   logic       zero_ext;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];

   // logical immediates are zero extended, all others sign extended
   assign zero_ext = (opcode == mips_pkg::op_andi) ||
                     (opcode == mips_pkg::op_ori)  ||
                     (opcode == mips_pkg::op_xori);

   always_comb begin
      fields.rs     = inst[25:21];
      fields.rt     = inst[20:16];
      fields.rd     = inst[15:11];
      fields.shamt  = inst[10:6];
      fields.imm    = zero_ext ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
      fields.target = inst[25:0];
   end

   always_comb begin
      // defaults describe a no-effect instruction
      ctrl.alu_op      = mips_pkg::alu_add;
      ctrl.alu_src_imm = 1'b0;
      ctrl.reg_write   = 1'b0;
      ctrl.dest_rd     = 1'b0;
      ctrl.link        = 1'b0;
      ctrl.mem_kind    = mips_pkg::mem_none;
      ctrl.pc_sel      = mips_pkg::pc_seq;
      ctrl.halt_req    = 1'b0;

      case (opcode)
         mips_pkg::op_rtype: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest_rd   = 1'b1;
            case (funct)
               mips_pkg::fn_add, mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
               mips_pkg::fn_sub, mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
               mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
               mips_pkg::fn_nor:  ctrl.alu_op = mips_pkg::alu_nor;
               mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
               mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
               mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
               mips_pkg::fn_sra:  ctrl.alu_op = mips_pkg::alu_sra;
               mips_pkg::fn_sllv: ctrl.alu_op = mips_pkg::alu_sllv;
               mips_pkg::fn_srlv: ctrl.alu_op = mips_pkg::alu_srlv;
               mips_pkg::fn_srav: ctrl.alu_op = mips_pkg::alu_srav;
               mips_pkg::fn_jr: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.pc_sel    = mips_pkg::pc_jreg;
               end
               // syscall and unknown funct both stop the core
               default: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.halt_req  = 1'b1;
               end
            endcase
         end
         mips_pkg::op_addi, mips_pkg::op_addiu: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         mips_pkg::op_slti, mips_pkg::op_andi, mips_pkg::op_ori,
         mips_pkg::op_xori, mips_pkg::op_lui: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            case (opcode)
               mips_pkg::op_slti: ctrl.alu_op = mips_pkg::alu_slt;
               mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
               mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
               mips_pkg::op_xori: ctrl.alu_op = mips_pkg::alu_xor;
               default:           ctrl.alu_op = mips_pkg::alu_lui;
            endcase
         end
         // loads: address is rs + offset
         mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            case (opcode)
               mips_pkg::op_lw: ctrl.mem_kind = mips_pkg::mem_lw;
               mips_pkg::op_lb: ctrl.mem_kind = mips_pkg::mem_lb;
               default:         ctrl.mem_kind = mips_pkg::mem_lbu;
            endcase
         end
         mips_pkg::op_sw, mips_pkg::op_sb: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_kind = (opcode == mips_pkg::op_sw) ? mips_pkg::mem_sw : mips_pkg::mem_sb;
         end
         mips_pkg::op_beq: ctrl.pc_sel = mips_pkg::pc_beq;
         mips_pkg::op_bne: ctrl.pc_sel = mips_pkg::pc_bne;
         mips_pkg::op_j:   ctrl.pc_sel = mips_pkg::pc_jump;
         mips_pkg::op_jal: begin
            ctrl.pc_sel    = mips_pkg::pc_jump;
            ctrl.link      = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         // reserved instruction
         default: ctrl.halt_req = 1'b1;
      endcase
   end

endmodule

// ==== logic/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc (
   input  logic                  clk,
   input  logic                  rst_b,
   input  mips_pkg::ctrl_t       ctrl,
   input  mips_pkg::inst_fields_t fields,
   input  mips_pkg::word_t       rs_data,
   input  mips_pkg::word_t       rt_data,
   output mips_pkg::word_t       pc,
   output mips_pkg::word_t       pc_plus4
);

   mips_pkg::word_t br_target;
   mips_pkg::word_t j_target;
   mips_pkg::word_t next_pc;
   logic            rs_eq_rt;

   assign pc_plus4 = pc + 32'd4;

   // offset is in words, relative to pc+4 (no delay slot)
   assign br_target = pc_plus4 + {fields.imm[29:0], 2'b00};
   // region bits come from pc+4
   assign j_target  = {pc_plus4[31:28], fields.target, 2'b00};
   assign rs_eq_rt  = (rs_data == rt_data);

   always_comb begin
      case (ctrl.pc_sel)
         mips_pkg::pc_beq:  next_pc = rs_eq_rt ? br_target : pc_plus4;
         mips_pkg::pc_bne:  next_pc = rs_eq_rt ? pc_plus4 : br_target;
         mips_pkg::pc_jump: next_pc = j_target;
         mips_pkg::pc_jreg: next_pc = rs_data;
         default:           next_pc = pc_plus4;
      endcase
   end

   // pc freezes on the halting instruction
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= mips_pkg::text_start;
      end else if (!ctrl.halt_req) begin
         pc <= next_pc;
      end
   end

endmodule

// ==== logic/mips_pkg.sv ====
package mips_pkg;

   // datapath and port widths
   localparam int word_w    = 32;
   localparam int addr_w    = 30;
   localparam int reg_idx_w = 5;

   typedef logic [word_w-1:0]    word_t;
   typedef logic [addr_w-1:0]    waddr_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   // pc after reset, start of the text segment
   localparam word_t text_start = 32'h00400000;

   // link register for jal
   localparam reg_idx_t reg_ra = 5'd31;

   // primary opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_j     = 6'h02;
   localparam logic [5:0] op_jal   = 6'h03;
   localparam logic [5:0] op_beq   = 6'h04;
   localparam logic [5:0] op_bne   = 6'h05;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_addiu = 6'h09;
   localparam logic [5:0] op_slti  = 6'h0a;
   localparam logic [5:0] op_andi  = 6'h0c;
   localparam logic [5:0] op_ori   = 6'h0d;
   localparam logic [5:0] op_xori  = 6'h0e;
   localparam logic [5:0] op_lui   = 6'h0f;
   localparam logic [5:0] op_lb    = 6'h20;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_lbu   = 6'h24;
   localparam logic [5:0] op_sb    = 6'h28;
   localparam logic [5:0] op_sw    = 6'h2b;

   // funct values under op_rtype
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_sllv    = 6'h04;
   localparam logic [5:0] fn_srlv    = 6'h06;
   localparam logic [5:0] fn_srav    = 6'h07;
   localparam logic [5:0] fn_jr      = 6'h08;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_add     = 6'h20;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_sub     = 6'h22;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;
   localparam logic [5:0] fn_nor     = 6'h27;
   localparam logic [5:0] fn_slt     = 6'h2a;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
      alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav, alu_lui
   } alu_op_t;

   // next pc source
   typedef enum logic [2:0] {
      pc_seq, pc_beq, pc_bne, pc_jump, pc_jreg
   } pc_sel_t;

   typedef enum logic [2:0] {
      mem_none, mem_lw, mem_lb, mem_lbu, mem_sw, mem_sb
   } mem_kind_t;

   // decoded instruction fields, 78 bits
   typedef struct packed {
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      reg_idx_t    shamt;
      word_t       imm;
      logic [25:0] target;
   } inst_fields_t;

   // control bundle, 15 bits
   typedef struct packed {
      alu_op_t   alu_op;
      logic      alu_src_imm;
      logic      reg_write;
      logic      dest_rd;
      logic      link;
      mem_kind_t mem_kind;
      pc_sel_t   pc_sel;
      logic      halt_req;
   } ctrl_t;

endpackage
